// File: dv/clockGen.sv
`timescale 1ns/100ps

module clockGen
#(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 8
)
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0; // Drops just after the last reset edge
  end

endmodule

// File: dv/routerOutputPortTb.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module routerOutputPortTb import flitPkg::*, arbPkg::*;
();

  localparam int NUM_PKTS       = 24; // Random packets per port
  localparam int MAX_LEN        = 8;
  localparam int MODEL_DEPTH    = 256;
  localparam int TOTAL_FLITS    = 4 * `NUM_PORTS + `NUM_PORTS * NUM_PKTS * MAX_LEN;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_FLITS + 2000;

  logic       clk;
  logic       rst;
  portMask_t  inValid;
  flitId_t    inId [`NUM_PORTS];
  flitData_t  inData [`NUM_PORTS];
  logic       outCredit;
  portMask_t  creditOut;
  logic       outValid;
  flitId_t    outId;
  flitData_t  outData;

  integer     seed = 32'h54b8;
  int         upCredits [`NUM_PORTS];
  int         sentFlits [`NUM_PORTS];
  int         creditCount [`NUM_PORTS];
  int         seqNo [`NUM_PORTS];
  flitId_t    expIdMem [`NUM_PORTS][MODEL_DEPTH];
  flitData_t  expDataMem [`NUM_PORTS][MODEL_DEPTH];
  int         expWr [`NUM_PORTS];
  int         expRd [`NUM_PORTS];
  portIdx_t   orderExp [$];
  int         heldCredits;
  logic       stall;
  logic       inPacket;
  portIdx_t   curPort;
  pktLength_t curLen;
  pktLength_t rxCount;

  clockGen #(.PERIOD(10), .RESET_CYCLES(8)) u_clockGen (.clk(clk), .rst(rst));

  routerOutputPort u_routerOutputPort
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inId      (inId),
    .inData    (inData),
    .outCredit (outCredit),
    .creditOut (creditOut),
    .outValid  (outValid),
    .outId     (outId),
    .outData   (outData)
  );

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkFlit(input flitId_t gotId, input flitData_t gotData,
                           input flitId_t expId, input flitData_t expData);
    if (gotId !== expId || gotData !== expData)
      abortRun($sformatf("CHECK FAILED @ %0t: flit id %b data %h, expected id %b data %h",
                         $time, gotId, gotData, expId, expData));
  endtask

  task automatic checkPort(input portIdx_t got, input portIdx_t exp, input string what);
    if (got !== exp)
      abortRun($sformatf("CHECK FAILED @ %0t: %s is port %0d, expected %0d",
                         $time, what, got, exp));
  endtask

  task automatic checkCount(input pktLength_t got, input pktLength_t exp, input string what);
    if (got !== exp)
      abortRun($sformatf("CHECK FAILED @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic checkReset();
    if (outValid !== 1'b0 || creditOut !== '0)
      abortRun($sformatf("CHECK FAILED @ %0t: outValid or creditOut high around reset", $time));
  endtask

  // Drives one flit and records it in that port's model queue
  task automatic driveFlit(input portIdx_t port, input flitId_t id, input flitData_t data);
    inValid[port] = 1'b1;
    inId[port]    = id;
    inData[port]  = data;
    upCredits[port]--;
    sentFlits[port]++;
    expIdMem[port][expWr[port] % MODEL_DEPTH]   = id;
    expDataMem[port][expWr[port] % MODEL_DEPTH] = data;
    expWr[port]++;
  endtask

  task automatic sendFlit(input portIdx_t port, input flitId_t id, input flitData_t data);
    logic sent;
    sent = 1'b0;
    while (!sent)
    begin
      @(posedge clk);
      #1;
      if (upCredits[port] > 0 && ({$random(seed)} % 4) != 0)
      begin
        driveFlit(port, id, data);
        sent = 1'b1;
      end
      else
        inValid[port] = 1'b0;
    end
  endtask

  task automatic producePackets(input portIdx_t port);
    pktLength_t len;
    flitId_t    id;
    for (int p = 0; p < NUM_PKTS; p++)
    begin
      len = pktLength_t'(MIN_PKT_LENGTH + {$random(seed)} % (MAX_LEN - 1));
      sendFlit(port, FLIT_HEADER, {port, 1'b0, len});
      for (int k = 1; k < len; k++)
      begin
        id = (k == len - 1) ? FLIT_TAIL : FLIT_BODY;
        sendFlit(port, id, {port, 13'(seqNo[port])}); // Source port sits in the top bits
        seqNo[port]++;
      end
    end
    @(posedge clk);
    #1 inValid[port] = 1'b0;
  endtask

  // All five ports start a 2-flit packet on the same edge
  task automatic sendRound();
    @(posedge clk);
    #1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      driveFlit(portIdx_t'(p), FLIT_HEADER, {portIdx_t'(p), 1'b0, MIN_PKT_LENGTH});
      orderExp.push_back(portIdx_t'(p));
    end
    @(posedge clk);
    #1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      driveFlit(portIdx_t'(p), FLIT_TAIL, {portIdx_t'(p), 13'(seqNo[p])});
      seqNo[p]++;
    end
    @(posedge clk);
    #1 inValid = '0;
  endtask

  task automatic waitDrained();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = (heldCredits != 0);
      for (int p = 0; p < `NUM_PORTS; p++)
        if (expRd[p] != expWr[p])
          busy = 1'b1;
    end
  endtask

  task automatic stallDownstream();
    repeat (150) @(posedge clk);
    stall = 1'b1;
    repeat (60) @(posedge clk);
    checkCount(pktLength_t'(heldCredits), `OUT_CREDITS, "flits held at end of credit stall");
    stall = 1'b0;
  endtask

  task automatic receiveFlit();
    portIdx_t src;
    int       slot;
    src = outData[15:13];
    heldCredits++;
    if (heldCredits > `OUT_CREDITS)
      abortRun($sformatf("CHECK FAILED @ %0t: %0d flits held downstream, only %0d credits",
                         $time, heldCredits, `OUT_CREDITS));
    if (src >= `NUM_PORTS || expRd[src] == expWr[src])
      abortRun($sformatf("At %0t a flit arrived that its source port never sent", $time));
    if (inPacket)
      checkPort(src, curPort, "source of a flit inside a packet");
    else
    begin
      if (orderExp.size() > 0)
        checkPort(src, orderExp.pop_front(), "next granted input");
      curPort  = src;
      inPacket = 1'b1;
      rxCount  = '0;
    end
    slot = expRd[src] % MODEL_DEPTH;
    checkFlit(outId, outData, expIdMem[src][slot], expDataMem[src][slot]);
    expRd[src]++;
    rxCount++;
    if (expIdMem[src][slot] == FLIT_HEADER)
      curLen = expDataMem[src][slot][`LENGTH_W-1:0];
    else if (expIdMem[src][slot] == FLIT_TAIL)
    begin
      checkCount(rxCount, curLen, "received packet length");
      inPacket = 1'b0;
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst && outValid)
      receiveFlit();
  end

  always @(negedge clk)
  begin
    if (!rst)
      for (int p = 0; p < `NUM_PORTS; p++)
        if (creditOut[p])
        begin
          creditCount[p]++;
          upCredits[p]++;
          if (upCredits[p] > `BUFFER_DEPTH)
            abortRun($sformatf("CHECK FAILED @ %0t: port %0d got more credits than it spent",
                               $time, p));
        end
  end

  // Downstream buffer frees slots at random unless stalled
  always @(posedge clk)
  begin
    #1;
    if (!rst && !stall && heldCredits > 0 && ({$random(seed)} % 2) == 0)
    begin
      outCredit = 1'b1;
      heldCredits--;
    end
    else
      outCredit = 1'b0;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abortRun("Timeout: the run ended before all flits were delivered");
  end

  initial
  begin
    inValid     = '0;
    outCredit   = 1'b0;
    stall       = 1'b0;
    inPacket    = 1'b0;
    heldCredits = 0;
    curPort     = '0;
    curLen      = '0;
    rxCount     = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inId[p]        = '0;
      inData[p]      = '0;
      upCredits[p]   = `BUFFER_DEPTH;
      sentFlits[p]   = 0;
      creditCount[p] = 0;
      seqNo[p]       = 0;
      expWr[p]       = 0;
      expRd[p]       = 0;
    end
    @(posedge clk); // Registers are unknown until the first reset edge
    @(negedge clk);
    while (rst)
    begin
      checkReset();
      @(negedge clk);
    end
    checkReset();
    sendRound();
    waitDrained();
    repeat (4) @(posedge clk);
    sendRound(); // After South the order wraps back to Local
    waitDrained();
    repeat (4) @(posedge clk);
    fork
      producePackets(3'd0);
      producePackets(3'd1);
      producePackets(3'd2);
      producePackets(3'd3);
      producePackets(3'd4);
      stallDownstream();
    join
    waitDrained();
    repeat (4) @(negedge clk);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      checkCount(pktLength_t'(creditCount[p]), pktLength_t'(sentFlits[p]), "creditOut pulses");
      checkCount(pktLength_t'(upCredits[p]), `BUFFER_DEPTH, "sender credits at end");
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/flitPkg.sv
rtl/arbPkg.sv
rtl/inputBuffer.sv
rtl/holdTimer.sv
rtl/outputArbiter.sv
rtl/outputLink.sv
rtl/routerOutputPort.sv
dv/clockGen.sv
dv/routerOutputPortTb.sv

// File: rtl/arbPkg.sv
`include "router_defines.svh"

package arbPkg;

  // Input side index, Local is 0 and South is 4
  typedef logic [$clog2(`NUM_PORTS)-1:0] portIdx_t;

  // One bit per input side
  typedef logic [`NUM_PORTS-1:0] portMask_t;

  // Output arbiter states, one grant state per input side
  typedef enum logic [2:0]
  {
    IDLE    = 3'd0,
    GRANT_L = 3'd1,
    GRANT_N = 3'd2,
    GRANT_E = 3'd3,
    GRANT_W = 3'd4,
    GRANT_S = 3'd5
  } arbState_t;

  localparam portIdx_t PORT_L = 0;
  localparam portIdx_t PORT_S = `NUM_PORTS - 1;

endpackage

// File: rtl/flitPkg.sv
`include "router_defines.svh"

package flitPkg;

  // Flit type code carried next to every payload
  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // Flit payload
  typedef logic [`FLIT_DATA_W-1:0] flitData_t;

  // Packet size in flits, header included
  typedef logic [`LENGTH_W-1:0] pktLength_t;

  // One-hot flit id codes
  localparam flitId_t FLIT_HEADER = 3'b001;
  localparam flitId_t FLIT_BODY   = 3'b010;
  localparam flitId_t FLIT_TAIL   = 3'b100;

  // A valid packet has at least a header and a tail
  localparam pktLength_t MIN_PKT_LENGTH = 2;

endpackage

// File: rtl/holdTimer.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module holdTimer import flitPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      pop,
  input  flitId_t   headId,
  input  flitData_t headData,
  output logic      done
);

  pktLength_t length;
  pktLength_t count;

  // Counts popped flits of the held packet, not cycles
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      length <= '0;
      count  <= '0;
    end
    else if (done)
      count <= '0; // Packet finished, ready for the next header
    else if (pop && headId == FLIT_HEADER)
    begin
      length <= headData[`LENGTH_W-1:0];
      count  <= pktLength_t'(1);
    end
    else if (pop)
      count <= count + 1'b1;
  end

  assign done = (count != '0) && (count == length);

endmodule

// File: rtl/inputBuffer.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module inputBuffer import flitPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      inValid,
  input  flitId_t   inId,
  input  flitData_t inData,
  input  logic      pop,
  output logic      headValid,
  output flitId_t   headId,
  output flitData_t headData,
  output logic      creditOut
);

  localparam int PTR_W = $clog2(`BUFFER_DEPTH);
  localparam int CNT_W = $clog2(`BUFFER_DEPTH + 1);

  flitId_t   idMem   [`BUFFER_DEPTH];
  flitData_t dataMem [`BUFFER_DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPop;

  assign doPop     = pop && headValid;
  assign headValid = (count != '0);
  assign headId    = idMem[rdPtr];
  assign headData  = dataMem[rdPtr];

  // The sender's credit count keeps a push away from a full buffer
  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      idMem[wrPtr]   <= inId;
      dataMem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      creditOut <= 1'b0;
    end
    else
    begin
      if (inValid)
        wrPtr <= (wrPtr == PTR_W'(`BUFFER_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PTR_W'(`BUFFER_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({inValid, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      creditOut <= doPop; // One credit back per flit that leaves
    end
  end

endmodule

// File: rtl/outputArbiter.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module outputArbiter import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t headValid,
  input  flitId_t   headId [`NUM_PORTS],
  input  flitData_t headData [`NUM_PORTS],
  input  logic      creditAvail,
  output portMask_t pop,
  output portIdx_t  sel
);

  arbState_t state;
  arbState_t nextState;
  portMask_t done;
  portIdx_t  rotStart;

  function automatic arbState_t idxToState(portIdx_t idx);
    case (idx)
      3'd0:    return GRANT_L;
      3'd1:    return GRANT_N;
      3'd2:    return GRANT_E;
      3'd3:    return GRANT_W;
      3'd4:    return GRANT_S;
      default: return IDLE;
    endcase
  endfunction

  function automatic portIdx_t stateToIdx(arbState_t st);
    case (st)
      GRANT_N: return 3'd1;
      GRANT_E: return 3'd2;
      GRANT_W: return 3'd3;
      GRANT_S: return 3'd4;
      default: return PORT_L;
    endcase
  endfunction

  // First requesting input at or after start, wrapping past South to Local
  function automatic arbState_t pickFrom(portMask_t req, portIdx_t start);
    arbState_t pick;
    int        idx;
    pick = IDLE;
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (int'(start) + k) % `NUM_PORTS;
      if (req[idx])
        pick = idxToState(portIdx_t'(idx));
    end
    return pick;
  endfunction

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gTimer
    holdTimer u_holdTimer
    (
      .clk      (clk),
      .rst      (rst),
      .pop      (pop[i]),
      .headId   (headId[i]),
      .headData (headData[i]),
      .done     (done[i])
    );
  end

  assign sel      = stateToIdx(state);
  assign rotStart = (sel == PORT_S) ? PORT_L : sel + 1'b1; // Served input goes last

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      IDLE:
        nextState = pickFrom(headValid, PORT_L);
      GRANT_L, GRANT_N, GRANT_E, GRANT_W, GRANT_S:
      begin
        if (done[sel])
          nextState = pickFrom(headValid, rotStart);
      end
      default:
        nextState = IDLE;
    endcase
  end

  // An empty granted buffer keeps the grant and simply stops popping
  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
      pop[i] = (state != IDLE) && (sel == i) && headValid[i] && creditAvail && !done[i];
  end

endmodule

// File: rtl/outputLink.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module outputLink import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitId_t   headId [`NUM_PORTS],
  input  flitData_t headData [`NUM_PORTS],
  input  portIdx_t  sel,
  input  portMask_t pop,
  input  logic      outCredit,
  output logic      creditAvail,
  output logic      outValid,
  output flitId_t   outId,
  output flitData_t outData
);

  localparam int CREDIT_W = $clog2(`OUT_CREDITS + 1);

  logic [CREDIT_W-1:0] credits;
  logic                anyPop;

  assign anyPop      = |pop;
  assign creditAvail = (credits != '0);

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= anyPop;
  end

  always_ff @(posedge clk)
  begin
    if (anyPop)
    begin
      outId   <= headId[sel];
      outData <= headData[sel];
    end
  end

  // Each flit sent uses one slot in the downstream buffer
  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= CREDIT_W'(`OUT_CREDITS);
    else
    begin
      case ({anyPop, outCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // Spend and return cancel out
      endcase
    end
  end

endmodule

// File: rtl/routerOutputPort.sv
`timescale 1ns/100ps
`include "router_defines.svh"

module routerOutputPort import flitPkg::*, arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t inValid,
  input  flitId_t   inId [`NUM_PORTS],
  input  flitData_t inData [`NUM_PORTS],
  input  logic      outCredit,
  output portMask_t creditOut,
  output logic      outValid,
  output flitId_t   outId,
  output flitData_t outData
);

  portMask_t headValid;
  flitId_t   headId [`NUM_PORTS];
  flitData_t headData [`NUM_PORTS];
  portMask_t pop;
  portIdx_t  sel;
  logic      creditAvail;

  // One buffer per input side, Local first
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gBuf
    inputBuffer u_inputBuffer
    (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[i]),
      .inId      (inId[i]),
      .inData    (inData[i]),
      .pop       (pop[i]),
      .headValid (headValid[i]),
      .headId    (headId[i]),
      .headData  (headData[i]),
      .creditOut (creditOut[i])
    );
  end

  outputArbiter u_outputArbiter
  (
    .clk         (clk),
    .rst         (rst),
    .headValid   (headValid),
    .headId      (headId),
    .headData    (headData),
    .creditAvail (creditAvail),
    .pop         (pop),
    .sel         (sel)
  );

  outputLink u_outputLink
  (
    .clk         (clk),
    .rst         (rst),
    .headId      (headId),
    .headData    (headData),
    .sel         (sel),
    .pop         (pop),
    .outCredit   (outCredit),
    .creditAvail (creditAvail),
    .outValid    (outValid),
    .outId       (outId),
    .outData     (outData)
  );

endmodule

// File: rtl/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Number of input sides feeding this output port (L, N, E, W, S)
`define NUM_PORTS 5

// Flit field widths
`define FLIT_ID_W 3
`define FLIT_DATA_W 16

// Packet length field, taken from the low bits of the header payload
`define LENGTH_W 12

// Input FIFO depth, which is also the upstream sender's starting credit
`define BUFFER_DEPTH 4

// Credits held for the downstream buffer after reset
`define OUT_CREDITS 4

`endif
